//--- filelist.f
verilog/dbg_cmd_pkg.sv
verilog/dbg_spr_pkg.sv
verilog/dbg_crc32.sv
verilog/dbg_spr_biu.sv
verilog/dbg_burst_fsm.sv
verilog/dbg_cpu_ctrl_reg.sv
verilog/dbg_or1k_module.sv
dv/tb_dbg_or1k.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the debug module testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dbg_or1k -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dbg_or1k)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
  exit 0
else
  exit 1
fi

//--- dv/tb_dbg_or1k.sv
// Testbench for the OR1K debug module: clock, reset, JTAG tasks, SPR model, CRC reference, checks
`timescale 1ns/10ps

module tb_dbg_or1k;
  import dbg_cmd_pkg::*;
  import dbg_spr_pkg::*;

  // Roughly 10 commands of 55 cycles, two write bursts of 170, one read of 140, plus slack
  localparam int TIMEOUT_CYCLES = 4000;
  localparam logic [31:0] LFSR_SEED = 32'h9cf1_c341;

  logic      tck_i    = 1'b0;
  logic      rst_i    = 1'b1;
  logic      tdi      = 1'b0;
  tap_ctrl_t tap      = '0;
  cmd_reg_t  dr       = '0;     // TAP data register model
  spr_rsp_t  spr_rsp  = '0;
  logic      cpu_bp   = 1'b0;
  spr_req_t  spr_req;
  logic      tdo, inhibit, cpu_stall, cpu_rst;

  spr_data_t   mem [64];           // SPR memory model
  logic [63:0] wr_exp [$];         // Expected writes, {addr, data}
  logic [31:0] stim_st = LFSR_SEED;  // Stimulus LFSR
  logic [31:0] dly_st  = LFSR_SEED;  // Ack delay LFSR
  logic [1:0]  ack_wait;
  logic        armed;
  int          errors = 0, wr_errors = 0, checks = 0, stb_cycles = 0, cycle_cnt = 0;

  always #5 tck_i = ~tck_i;  // 10 ns period

  dbg_or1k_module u_dbg_or1k_module (
    .tck_i(tck_i), .rst_i(rst_i), .tdi_i(tdi), .tap_i(tap), .data_register_i(dr),
    .module_tdo_o(tdo), .top_inhibit_o(inhibit), .spr_req_o(spr_req), .spr_rsp_i(spr_rsp),
    .cpu_bp_i(cpu_bp), .cpu_stall_o(cpu_stall), .cpu_rst_o(cpu_rst)
  );

  //////////////////////////////////////////////////////////////
  // Reference models
  //////////////////////////////////////////////////////////////
  // Fibonacci LFSR, taps 32 22 2 1, new bit lands in bit 0
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Reflected CRC-32, all-ones start, no final inversion, bits[0] first
  function automatic logic [31:0] crc32_ref(input logic [127:0] bits, input int n);
    logic [31:0] c;
    c = '1;
    for (int i = 0; i < n; i++) begin
      if (c[0] ^ bits[i]) c = (c >> 1) ^ 32'hedb8_8320;
      else c = c >> 1;
    end
    return c;
  endfunction

  // TAP data register: capture clears, shift moves right with tdi into the MSB
  always @(posedge tck_i) begin
    if (tap.capture) dr <= '0;
    else if (tap.shift) dr <= {tdi, dr[DR_WIDTH-1:1]};
  end

  // SPR slave, ack after 1 to 3 cycles
  always @(posedge tck_i) begin
    logic [1:0] dv;
    if (rst_i) begin
      for (int k = 0; k < 64; k++) mem[k] <= 32'h5a3c_0000 ^ (32'(k) * 32'h0101_0107);
      armed       <= 1'b0;
      ack_wait    <= 2'd0;
      spr_rsp.ack <= 1'b0;
    end else begin
      spr_rsp.ack <= 1'b0;
      if (spr_req.stb && !spr_rsp.ack) begin
        if (!armed) begin
          dly_st = lfsr_next(dly_st);
          dv[0]  = dly_st[0];
          dly_st = lfsr_next(dly_st);
          dv[1]  = dly_st[0];
          armed    <= 1'b1;
          ack_wait <= (dv == 2'd3) ? 2'd2 : dv + 2'd1;
        end else if (ack_wait > 2'd1) begin
          ack_wait <= ack_wait - 2'd1;
        end else begin
          armed       <= 1'b0;
          spr_rsp.ack <= 1'b1;
          if (spr_req.we) mem[spr_req.addr[5:0]] <= spr_req.wdata;
          else spr_rsp.rdata <= mem[spr_req.addr[5:0]];
        end
      end
    end
  end

  // Write stream compare against the expected queue
  always @(posedge tck_i) begin
    logic [63:0] e;
    if (spr_rsp.ack && spr_req.we) begin
      assert (wr_exp.size() != 0) else begin
        $display("[ERROR] %0t SPR write to %h arrived with no write expected", $time,
                 spr_req.addr);
        wr_errors++;
      end
      if (wr_exp.size() != 0) begin
        e = wr_exp.pop_front();
        assert ({spr_req.addr, spr_req.wdata} === e) else begin
          $display("[ERROR] %0t spr_req_o addr/wdata got %h/%h expected %h/%h", $time,
                   spr_req.addr, spr_req.wdata, e[63:32], e[31:0]);
          wr_errors++;
        end
      end
    end
    if (spr_req.stb) stb_cycles <= stb_cycles + 1;  // Bus activity monitor
  end

  // Run limit
  always @(posedge tck_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////
  // Tasks
  //////////////////////////////////////////////////////////////
  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // One TCK cycle of TAP controls, tdo sampled mid-cycle
  task automatic jtag_cycle(input logic cap, sh, upd, t, output logic tdo_v);
    @(posedge tck_i);
    tap <= {cap, sh, upd, 1'b1};
    tdi <= t;
    @(negedge tck_i);
    tdo_v = tdo;
  endtask

  task automatic send_cmd(input cmd_reg_t cmd);
    logic t;
    for (int i = 0; i < DR_WIDTH; i++) jtag_cycle(1'b0, 1'b1, 1'b0, cmd[i], t);
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);  // Update
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
  endtask

  task automatic ireg_write(input logic [1:0] d);
    send_cmd({1'b0, CMD_IREG_WR, 1'b0, d, 45'd0});
    check_val("cpu_stall_o", {31'd0, cpu_stall}, {31'd0, d[0]});
    check_val("cpu_rst_o", {31'd0, cpu_rst}, {31'd0, d[1]});
  endtask

  task automatic ireg_read(input logic [1:0] exp);
    logic [31:0] got;
    logic        t;
    jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);  // Capture loads the readback word
    for (int i = 0; i < 32; i++) jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, got[i]);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    check_val("ctrl readback", got, {30'd0, exp});
  endtask

  task automatic burst_write(input logic [31:0] base, input logic flip);
    logic [127:0] bits;
    logic [31:0]  w, a, crc;
    logic         t;
    for (int n = 0; n < 4; n++) begin
      for (int b = 0; b < 32; b++) begin
        stim_st = lfsr_next(stim_st);
        w[b]    = stim_st[0];
      end
      bits[n*32 +: 32] = w;
      wr_exp.push_back({base + 32'(n), w});
    end
    crc = crc32_ref(bits, 128);
    if (flip) crc[5] = ~crc[5];  // Corrupt one CRC bit
    send_cmd({1'b0, CMD_BWRITE32, base, 16'd4});
    jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
    jtag_cycle(1'b0, 1'b1, 1'b0, 1'b1, t);  // Start bit
    for (int i = 0; i < 128; i++) begin
      jtag_cycle(1'b0, 1'b1, 1'b0, bits[i], t);
      if (i == 0 || i == 100) check_val("top_inhibit_o", {31'd0, inhibit}, 32'd1);
    end
    for (int i = 0; i < 32; i++) jtag_cycle(1'b0, 1'b1, 1'b0, crc[i], t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);  // Match bit on TDO
    check_val("crc match", {31'd0, t}, {31'd0, ~flip});
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    for (int k = 0; k < 20 && wr_exp.size() != 0; k++) @(posedge tck_i);
    assert (wr_exp.size() == 0) else begin
      $display("[ERROR] %0t %0d SPR writes never reached the bus", $time, wr_exp.size());
      errors++;
    end
    for (int n = 0; n < 4; n++) begin
      a = base + 32'(n);
      check_val($sformatf("mem[%0d]", a), mem[a[5:0]], bits[n*32 +: 32]);
    end
  endtask

  task automatic burst_read(input logic [31:0] base);
    logic [127:0] bits;
    logic [31:0]  crc, a;
    logic         t, rdy;
    int           polls;
    bits = '0;
    send_cmd({1'b0, CMD_BREAD32, base, 16'd3});
    rdy   = 1'b0;
    polls = 0;
    while (!rdy && polls < 8) begin  // Poll the ready bit with a fresh capture
      jtag_cycle(1'b1, 1'b0, 1'b0, 1'b0, t);
      jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, rdy);
      polls++;
    end
    check_val("ready bit", {31'd0, rdy}, 32'd1);
    jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, t);  // Shift past the ready bit
    for (int i = 0; i < 96; i++) jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, bits[i]);
    for (int i = 0; i < 32; i++) jtag_cycle(1'b0, 1'b1, 1'b0, 1'b0, crc[i]);
    jtag_cycle(1'b0, 1'b0, 1'b1, 1'b0, t);
    jtag_cycle(1'b0, 1'b0, 1'b0, 1'b0, t);
    for (int n = 0; n < 3; n++) begin
      a = base + 32'(n);
      check_val($sformatf("read word %0d", n), bits[n*32 +: 32], mem[a[5:0]]);
    end
    check_val("read crc", crc, crc32_ref(bits, 96));
  endtask

  //////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////
  initial begin
    int stb_before;
    repeat (3) @(posedge tck_i);
    rst_i <= 1'b0;
    @(negedge tck_i);
    check_val("spr_req_o.stb", {31'd0, spr_req.stb}, 32'd0);  // Quiet after reset
    check_val("spr_req_o.we", {31'd0, spr_req.we}, 32'd0);
    check_val("cpu_stall_o", {31'd0, cpu_stall}, 32'd0);
    check_val("cpu_rst_o", {31'd0, cpu_rst}, 32'd0);
    check_val("top_inhibit_o", {31'd0, inhibit}, 32'd0);

    ireg_write(2'b01);
    ireg_read(2'b01);
    ireg_write(2'b10);
    ireg_read(2'b10);
    @(posedge tck_i);
    cpu_bp <= 1'b1;  // Breakpoint pulse
    @(posedge tck_i);
    cpu_bp <= 1'b0;
    @(negedge tck_i);
    check_val("cpu_stall_o", {31'd0, cpu_stall}, 32'd1);
    ireg_read(2'b11);
    ireg_write(2'b00);

    burst_write(32'd8, 1'b0);
    burst_write(32'd8, 1'b1);
    burst_read(32'd8);

    // Empty burst leaves the bus idle
    stb_before = stb_cycles;
    send_cmd({1'b0, CMD_BREAD32, 32'd8, 16'd0});
    repeat (4) @(posedge tck_i);
    check_val("stb cycles", 32'(stb_cycles - stb_before), 32'd0);
    ireg_read(2'b00);

    errors = errors + wr_errors;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- verilog/dbg_or1k_module.sv
// OR1K debug module top: counters, opcode latch, output shifter, TDO mux, submodules
`timescale 1ns/10ps

module dbg_or1k_module (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   tdi_i,            // One bit ahead of data register MSB
  input  dbg_cmd_pkg::tap_ctrl_t tap_i,
  input  dbg_cmd_pkg::cmd_reg_t  data_register_i,
  output logic                   module_tdo_o,
  output logic                   top_inhibit_o,
  output dbg_spr_pkg::spr_req_t  spr_req_o,
  input  dbg_spr_pkg::spr_rsp_t  spr_rsp_i,
  input  logic                   cpu_bp_i,
  output logic                   cpu_stall_o,
  output logic                   cpu_rst_o
);
  import dbg_cmd_pkg::*;
  import dbg_spr_pkg::*;

  burst_ctrl_t ctrl;
  burst_stat_t stat;
  spr_addr_t   addr_q;     // Next SPR address
  word_count_t word_q;     // Words left
  bit_count_t  bit_q;      // Bits done in current word
  opcode_t     op_q;       // Latched burst opcode
  spr_data_t   out_q;      // Output shift register, LSB first
  spr_data_t   bus_wdata, bus_rdata, ctrl_word, crc_val;
  logic        ctrl_wr, crc_in, crc_serial, crc_match;

  ////////////////////////////////////////////////////////////
  // Counters and latches
  ////////////////////////////////////////////////////////////
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= '0;
      word_q <= '0;
      bit_q  <= '0;
      op_q   <= '0;
      out_q  <= '0;
    end else begin
      if (ctrl.addr_load)     addr_q <= data_register_i[ADDR_MSB -: SPR_ADDR_W];
      else if (ctrl.addr_inc) addr_q <= addr_q + SPR_ADDR_STEP;
      if (ctrl.word_load)     word_q <= data_register_i[COUNT_MSB:0];
      else if (ctrl.word_dec) word_q <= word_q - word_count_t'(1);
      if (ctrl.bit_clr)       bit_q  <= '0;
      else if (ctrl.bit_inc)  bit_q  <= bit_q + bit_count_t'(1);
      if (ctrl.op_load)       op_q   <= data_register_i[OPCODE_MSB -: $bits(opcode_t)];
      if (ctrl.out_load)      out_q  <= ctrl.out_from_bus ? bus_rdata : ctrl_word;
      else if (ctrl.out_shift) out_q <= {1'b0, out_q[SPR_DATA_W-1:1]};
    end
  end

  assign stat.word_zero = (word_q == '0);
  assign stat.word_last = (word_q == word_count_t'(1));  // Last word already fetched
  assign stat.bit_last  = (bit_q == bit_count_t'(WORD_LAST_BIT));
  assign stat.bit_32    = (bit_q == bit_count_t'(CRC_BITS));

  assign ctrl_word = {{(SPR_DATA_W-CTRL_W){1'b0}}, cpu_rst_o, cpu_stall_o};
  assign bus_wdata = {tdi_i, data_register_i[TOP_FLAG_BIT -: SPR_DATA_W-1]};  // tdi is bit 31
  assign crc_in    = ctrl.crc_from_tdi ? tdi_i : out_q[0];
  assign crc_match = (data_register_i[TOP_FLAG_BIT -: CRC_BITS] == crc_val);

  // TDO source select
  always_comb begin
    unique case (ctrl.tdo_sel)
      READY:   module_tdo_o = stat.bus_ready;
      DATA:    module_tdo_o = out_q[0];
      MATCH:   module_tdo_o = crc_match;
      default: module_tdo_o = crc_serial;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Submodules
  ////////////////////////////////////////////////////////////
  dbg_burst_fsm u_fsm (
    .tck_i(tck_i), .rst_i(rst_i), .tap_i(tap_i), .cmd_i(data_register_i),
    .stat_i(stat), .ctrl_o(ctrl), .ctrl_wr_o(ctrl_wr), .inhibit_o(top_inhibit_o)
  );

  dbg_spr_biu u_biu (
    .tck_i(tck_i), .rst_i(rst_i), .strobe_i(ctrl.bus_strobe), .rd_i(op_q[RD_OP_BIT]),
    .addr_i(addr_q), .wdata_i(bus_wdata), .rdata_o(bus_rdata), .ready_o(stat.bus_ready),
    .spr_req_o(spr_req_o), .spr_rsp_i(spr_rsp_i)
  );

  dbg_crc32 u_crc (
    .tck_i(tck_i), .rst_i(rst_i), .bit_i(crc_in), .en_i(ctrl.crc_en),
    .shift_i(ctrl.crc_shift), .clr_i(ctrl.crc_clr), .crc_o(crc_val), .serial_o(crc_serial)
  );

  dbg_cpu_ctrl_reg u_ctrl_reg (
    .tck_i(tck_i), .rst_i(rst_i), .we_i(ctrl_wr),
    .data_i(data_register_i[CTRL_DATA_MSB -: CTRL_W]), .bp_i(cpu_bp_i),
    .stall_o(cpu_stall_o), .rst_o(cpu_rst_o)
  );

endmodule

//--- verilog/dbg_cpu_ctrl_reg.sv
// CPU control register: stall and reset bits, stall latched on breakpoint
`timescale 1ns/10ps

module dbg_cpu_ctrl_reg (
  input  logic                           tck_i,
  input  logic                           rst_i,
  input  logic                           we_i,
  input  logic [dbg_cmd_pkg::CTRL_W-1:0] data_i,
  input  logic                           bp_i,     // CPU breakpoint hit
  output logic                           stall_o,
  output logic                           rst_o
);
  import dbg_cmd_pkg::*;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_o <= 1'b0;
      rst_o   <= 1'b0;
    end else begin
      if (bp_i) begin
        stall_o <= 1'b1;  // Breakpoint beats a clearing write
      end else if (we_i) begin
        stall_o <= data_i[CTRL_STALL_BIT];
      end
      if (we_i) rst_o <= data_i[CTRL_RST_BIT];
    end
  end

endmodule

//--- verilog/dbg_burst_fsm.sv
// Control FSM: command decode, burst read/write sequencing, control register writes
`timescale 1ns/10ps

module dbg_burst_fsm (
  input  logic                     tck_i,
  input  logic                     rst_i,
  input  dbg_cmd_pkg::tap_ctrl_t   tap_i,
  input  dbg_cmd_pkg::cmd_reg_t    cmd_i,
  input  dbg_cmd_pkg::burst_stat_t stat_i,
  output dbg_cmd_pkg::burst_ctrl_t ctrl_o,
  output logic                     ctrl_wr_o,  // Control register write
  output logic                     inhibit_o   // Burst owns TDO
);
  import dbg_cmd_pkg::*;

  burst_state_e state_q, state_d;
  opcode_t      op_in;      // Opcode straight from the data register
  logic         mod_cmd;    // Command addressed to this module
  logic         sel_cap, sel_sh, sel_upd;
  logic         burst_cmd, ireg_cmd;

  ////////////////////////////////////////////////////////////
  // Command decode
  ////////////////////////////////////////////////////////////
  assign op_in     = cmd_i[OPCODE_MSB -: $bits(opcode_t)];
  assign mod_cmd   = ~cmd_i[TOP_FLAG_BIT];
  assign sel_cap   = tap_i.select & tap_i.capture;
  assign sel_sh    = tap_i.select & tap_i.shift;
  assign sel_upd   = tap_i.select & tap_i.update;
  assign burst_cmd = (op_in == CMD_BWRITE32) | (op_in == CMD_BREAD32);
  assign ireg_cmd  = (op_in == CMD_IREG_WR) | (op_in == CMD_IREG_SEL);

  assign ctrl_wr_o = (state_q == IDLE) & sel_upd & mod_cmd & (op_in == CMD_IREG_WR);
  assign inhibit_o = state_q inside {RSTATUS, RBURST, RCRC, WWAIT, WBURST, WCRC, WMATCH};

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Next state and datapath enables
  ////////////////////////////////////////////////////////////
  always_comb begin
    state_d        = state_q;
    ctrl_o         = '0;
    ctrl_o.tdo_sel = DATA;
    unique case (state_q)
      IDLE: begin
        ctrl_o.out_shift = sel_sh;  // Control register readback
        // Capture, select or write refresh the readback word
        ctrl_o.out_load  = sel_cap | (sel_upd & mod_cmd & ireg_cmd);
        if (sel_upd && mod_cmd && burst_cmd) begin
          state_d          = (op_in == CMD_BREAD32) ? RBEGIN : WREADY;
          ctrl_o.addr_load = 1'b1;
          ctrl_o.op_load   = 1'b1;
          ctrl_o.bit_clr   = 1'b1;
          ctrl_o.word_load = 1'b1;
          ctrl_o.crc_clr   = 1'b1;
        end
      end
      RBEGIN: begin
        if (stat_i.word_zero) begin
          state_d = IDLE;  // Empty burst, no bus traffic
        end else begin
          state_d           = RREADY;
          ctrl_o.bus_strobe = 1'b1;  // Fetch first word
          ctrl_o.addr_inc   = 1'b1;
        end
      end
      RREADY: begin
        if (sel_cap) state_d = RSTATUS;
      end
      RSTATUS: begin
        ctrl_o.tdo_sel = READY;  // Host polls this bit
        if (sel_sh && stat_i.bus_ready) begin
          state_d             = RBURST;
          ctrl_o.out_load     = 1'b1;
          ctrl_o.out_from_bus = 1'b1;
          ctrl_o.bit_clr      = 1'b1;
          ctrl_o.word_dec     = 1'b1;
          ctrl_o.bus_strobe   = ~stat_i.word_last;  // Prefetch next word
          ctrl_o.addr_inc     = ~stat_i.word_last;
        end
      end
      RBURST: begin
        ctrl_o.out_shift = sel_sh;
        ctrl_o.bit_inc   = sel_sh;
        ctrl_o.crc_en    = sel_sh;  // CRC over the outgoing bits
        if (sel_sh && stat_i.bit_last) begin
          if (stat_i.word_zero) begin
            state_d = RCRC;
          end else begin
            ctrl_o.out_load     = 1'b1;
            ctrl_o.out_from_bus = 1'b1;
            ctrl_o.bit_clr      = 1'b1;
            ctrl_o.word_dec     = 1'b1;
            ctrl_o.bus_strobe   = ~stat_i.word_last;
            ctrl_o.addr_inc     = ~stat_i.word_last;
          end
        end
      end
      RCRC: begin
        ctrl_o.tdo_sel   = CRC;
        ctrl_o.crc_shift = sel_sh;  // Stays here until update
      end
      WREADY: begin
        if (stat_i.word_zero) begin
          state_d = IDLE;
        end else if (sel_cap) begin
          state_d = WWAIT;
        end
      end
      WWAIT: begin
        // Start bit seen, tdi carries data bit 0 now
        if (sel_sh && cmd_i[TOP_FLAG_BIT]) begin
          state_d             = WBURST;
          ctrl_o.bit_inc      = 1'b1;
          ctrl_o.word_dec     = 1'b1;  // Count pre-decremented
          ctrl_o.crc_en       = 1'b1;
          ctrl_o.crc_from_tdi = 1'b1;
        end
      end
      WBURST: begin
        ctrl_o.bit_inc      = sel_sh;
        ctrl_o.crc_en       = sel_sh;
        ctrl_o.crc_from_tdi = 1'b1;
        if (sel_sh && stat_i.bit_last) begin
          ctrl_o.bit_clr    = 1'b1;
          ctrl_o.bus_strobe = 1'b1;  // Word complete, write it
          ctrl_o.addr_inc   = 1'b1;
          ctrl_o.word_dec   = ~stat_i.word_zero;
          if (stat_i.word_zero) state_d = WCRC;
        end
      end
      WCRC: begin
        ctrl_o.bit_inc = sel_sh;  // Count the incoming CRC bits
        if (stat_i.bit_32) begin
          state_d        = WMATCH;
          ctrl_o.tdo_sel = MATCH;
        end
      end
      WMATCH: ctrl_o.tdo_sel = MATCH;
      default: state_d = IDLE;
    endcase
    // Any update ends a burst
    if (tap_i.update && state_q != IDLE) state_d = IDLE;
  end

  assert property (@(posedge tck_i) disable iff (rst_i)
    !$isunknown(state_q) && (state_q inside {IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
                                             WREADY, WWAIT, WBURST, WCRC, WMATCH}))
    else $error("burst_fsm: illegal state");

endmodule

//--- verilog/dbg_spr_biu.sv
// SPR bus interface unit: latches one transfer and runs the stb/ack handshake
`timescale 1ns/10ps

module dbg_spr_biu (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   strobe_i,   // Start a transfer
  input  logic                   rd_i,       // 1 read, 0 write
  input  dbg_spr_pkg::spr_addr_t addr_i,
  input  dbg_spr_pkg::spr_data_t wdata_i,
  output dbg_spr_pkg::spr_data_t rdata_o,
  output logic                   ready_o,    // Low while a transfer is pending
  output dbg_spr_pkg::spr_req_t  spr_req_o,
  input  dbg_spr_pkg::spr_rsp_t  spr_rsp_i
);
  import dbg_spr_pkg::*;

  spr_addr_t addr_q;
  spr_data_t wdata_q;
  spr_data_t rdata_q;
  logic      we_q;
  logic      stb_q;
  logic      done;  // Ack for the pending transfer

  assign done = stb_q & spr_rsp_i.ack;

  ////////////////////////////////////////////////////////////
  // Handshake control
  ////////////////////////////////////////////////////////////
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q <= 1'b0;
      we_q  <= 1'b0;
    end else if (strobe_i) begin
      stb_q <= 1'b1;   // Request goes out next cycle
      we_q  <= ~rd_i;
    end else if (done) begin
      stb_q <= 1'b0;   // Drop on the edge after ack
    end
  end

  // Transfer payload, captured with the strobe
  always_ff @(posedge tck_i) begin
    if (strobe_i) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  // Read data sampled in the ack cycle
  always_ff @(posedge tck_i) begin
    if (done && !we_q) begin
      rdata_q <= spr_rsp_i.rdata;
    end
  end

  assign rdata_o         = rdata_q;
  assign ready_o         = ~stb_q;  // High again the cycle after ack
  assign spr_req_o.addr  = addr_q;
  assign spr_req_o.wdata = wdata_q;
  assign spr_req_o.stb   = stb_q;
  assign spr_req_o.we    = stb_q & we_q;  // No stray we outside a transfer

  // FSM must wait for the previous transfer before the next strobe
  assert property (@(posedge tck_i) disable iff (rst_i) strobe_i |-> ready_o)
    else $error("spr_biu: strobe while busy");

endmodule

//--- verilog/dbg_crc32.sv
// Bit-serial reflected CRC-32 register with built-in serial output shift
`timescale 1ns/10ps

module dbg_crc32 (
  input  logic                   tck_i,
  input  logic                   rst_i,
  input  logic                   bit_i,     // Serial data in
  input  logic                   en_i,      // One CRC step
  input  logic                   shift_i,   // Shift out, zero fill
  input  logic                   clr_i,     // Back to all ones
  output dbg_spr_pkg::spr_data_t crc_o,
  output logic                   serial_o
);
  import dbg_cmd_pkg::*;
  import dbg_spr_pkg::*;

  spr_data_t crc_q;
  logic      fb;  // Feedback bit

  assign fb = crc_q[0] ^ bit_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= '1;
    end else if (clr_i) begin
      crc_q <= '1;
    end else if (en_i) begin
      crc_q <= (crc_q >> 1) ^ (fb ? CRC_POLY : '0);  // Right shift, poly on feedback
    end else if (shift_i) begin
      crc_q <= crc_q >> 1;  // Acts as output shifter
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];  // LSB leaves first

  // Stepping and shifting at once would corrupt the result
  assert property (@(posedge tck_i) disable iff (rst_i) !(en_i && shift_i))
    else $error("crc32: enable and shift together");

endmodule

//--- verilog/dbg_spr_pkg.sv
// CPU SPR bus side: address and data types, request and response structs
package dbg_spr_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int SPR_ADDR_W = 32;
  localparam int SPR_DATA_W = 32;

  typedef logic [SPR_ADDR_W-1:0] spr_addr_t;  // Word address
  typedef logic [SPR_DATA_W-1:0] spr_data_t;

  // SPRs are word addressed, one step per word
  localparam spr_addr_t SPR_ADDR_STEP = 32'd1;

  ////////////////////////////////////////////////////////////
  // Bus bundles
  ////////////////////////////////////////////////////////////
  // Request, held until ack
  typedef struct packed {
    spr_addr_t addr;
    spr_data_t wdata;
    logic      stb;
    logic      we;
  } spr_req_t;

  // Response, rdata valid with ack
  typedef struct packed {
    spr_data_t rdata;
    logic      ack;
  } spr_rsp_t;

endpackage

//--- verilog/dbg_cmd_pkg.sv
// JTAG command side: data register layout, opcodes, counter types, FSM states, control structs
package dbg_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // Data register layout
  ////////////////////////////////////////////////////////////
  localparam int DR_WIDTH      = 53;
  localparam int TOP_FLAG_BIT  = 52;  // 0 means the command is ours
  localparam int OPCODE_MSB    = 51;
  localparam int ADDR_MSB      = 47;
  localparam int COUNT_MSB     = 15;
  localparam int CTRL_DATA_MSB = 46;  // Control write data in 46:45

  typedef logic [DR_WIDTH-1:0] cmd_reg_t;

  // Opcodes, bit 2 set marks a read
  typedef logic [3:0] opcode_t;
  localparam opcode_t CMD_BWRITE32 = 4'd3;
  localparam opcode_t CMD_BREAD32  = 4'd7;
  localparam opcode_t CMD_IREG_WR  = 4'd9;
  localparam opcode_t CMD_IREG_SEL = 4'd13;
  localparam int      RD_OP_BIT    = 2;

  // Counters and CRC
  typedef logic [COUNT_MSB:0] word_count_t;
  typedef logic [5:0]         bit_count_t;
  localparam int WORD_LAST_BIT = 31;  // Bit count of the last bit in a word
  localparam int CRC_BITS      = 32;
  localparam logic [CRC_BITS-1:0] CRC_POLY = 32'hedb8_8320;  // Reflected CRC-32

  // Control register bits
  localparam int CTRL_W         = 2;
  localparam int CTRL_STALL_BIT = 0;
  localparam int CTRL_RST_BIT   = 1;

  ////////////////////////////////////////////////////////////
  // FSM states and control bundles
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    IDLE, RBEGIN, RREADY, RSTATUS, RBURST, RCRC,
    WREADY, WWAIT, WBURST, WCRC, WMATCH
  } burst_state_e;

  typedef enum logic [1:0] {READY, DATA, MATCH, CRC} tdo_sel_e;  // TDO sources

  typedef struct packed {
    logic capture;
    logic shift;
    logic update;
    logic select;  // Module selected by top level
  } tap_ctrl_t;

  typedef struct packed {
    logic addr_load, addr_inc;
    logic op_load;
    logic bit_clr, bit_inc;
    logic word_load, word_dec;
    logic out_load, out_shift, out_from_bus;
    logic bus_strobe;
    logic crc_clr, crc_en, crc_from_tdi, crc_shift;
    tdo_sel_e tdo_sel;
  } burst_ctrl_t;

  typedef struct packed {
    logic word_zero, word_last;
    logic bit_last, bit_32;
    logic bus_ready;
  } burst_stat_t;

endpackage
